/* Bender.yml */
package:
  name: cache_conf_stage

sources:
  - files:
      - hw/cache_conf_pkg.sv
      - hw/axis_clip_if.sv
      - hw/ref_axis_clip.sv
      - hw/conf_register.sv
      - hw/cache_conf_stage.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/tb_cache_conf_stage.sv

/* cache_conf_stage.f */
+incdir+verification
hw/cache_conf_pkg.sv
hw/axis_clip_if.sv
hw/ref_axis_clip.sv
hw/conf_register.sv
hw/cache_conf_stage.sv
verification/tb_cache_conf_stage.sv

/* hw/axis_clip_if.sv */
interface axis_clip_if #(
   parameter type start_t = cache_conf_pkg::xaddr_t,
   parameter type dim_t   = cache_conf_pkg::luma_dim_t
);

   // clamped fetch start, already divided down for chroma
   start_t clip_start;

   // part of the request inside the picture
   dim_t span;

   // first and last position inside the cache block
   dim_t offset;
   dim_t block_end;

   modport src (
      output clip_start,
      output span,
      output offset,
      output block_end
   );

   modport dst (
      input clip_start,
      input span,
      input offset,
      input block_end
   );

endinterface

/* hw/cache_conf_pkg.sv */
package cache_conf_pkg;

   // ----------------------------------------------------------------------
   // widths
   // ----------------------------------------------------------------------

   // signed integer-pel coordinates and picture dimensions
   localparam int COORD_W = 16;

   // clamped luma fetch start, x and y sized separately
   localparam int X_ADDR_W = 12;
   localparam int Y_ADDR_W = 12;

   // spans, offsets and ends inside one cache block
   localparam int LUMA_DIM_W = 7;
   localparam int CHMA_DIM_W = 6;

   localparam int REF_IDX_W = 4;

   // ----------------------------------------------------------------------
   // types
   // ----------------------------------------------------------------------

   typedef logic signed [COORD_W-1:0] coord_t;

   typedef logic [X_ADDR_W-1:0] xaddr_t;
   typedef logic [Y_ADDR_W-1:0] yaddr_t;

   typedef logic [LUMA_DIM_W-1:0] luma_dim_t;
   typedef logic [CHMA_DIM_W-1:0] chma_dim_t;

   typedef logic [REF_IDX_W-1:0] ref_idx_t;

   // ----------------------------------------------------------------------
   // default cache block geometry
   // ----------------------------------------------------------------------

   // luma block is square
   localparam int DEF_LUMA_BLOCK_DIM = 64;

   // 4:2:0 chroma block
   localparam int DEF_CHMA_BLOCK_WDT = 32;
   localparam int DEF_CHMA_BLOCK_HGT = 32;

endpackage

/* hw/cache_conf_stage.sv */
module cache_conf_stage #(
   parameter int LUMA_BLOCK_DIM = cache_conf_pkg::DEF_LUMA_BLOCK_DIM,
   parameter int CHMA_BLOCK_WDT = cache_conf_pkg::DEF_CHMA_BLOCK_WDT,
   parameter int CHMA_BLOCK_HGT = cache_conf_pkg::DEF_CHMA_BLOCK_HGT,
   parameter int C_SUB_X_SHIFT  = 1,
   parameter int C_SUB_Y_SHIFT  = 1
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      valid_in,
   input  logic                      is_req_read,
   input  logic                      tag_compare_stage_ready,

   input  cache_conf_pkg::coord_t    pic_width,
   input  cache_conf_pkg::coord_t    pic_height,
   input  cache_conf_pkg::ref_idx_t  ref_idx_in,

   input  cache_conf_pkg::coord_t    luma_ref_start_x,
   input  cache_conf_pkg::coord_t    luma_ref_start_y,
   input  cache_conf_pkg::coord_t    chma_ref_start_x,
   input  cache_conf_pkg::coord_t    chma_ref_start_y,
   input  cache_conf_pkg::luma_dim_t luma_ref_width_x,
   input  cache_conf_pkg::luma_dim_t luma_ref_height_y,
   input  cache_conf_pkg::luma_dim_t chma_ref_width_x,
   input  cache_conf_pkg::luma_dim_t chma_ref_height_y,

   output logic                      op_conf_fifo_wr_en,
   output cache_conf_pkg::ref_idx_t  ref_idx,

   output cache_conf_pkg::xaddr_t    start_x_luma,
   output cache_conf_pkg::yaddr_t    start_y_luma,
   output logic [cache_conf_pkg::X_ADDR_W-C_SUB_X_SHIFT-1:0] start_x_chma,
   output logic [cache_conf_pkg::Y_ADDR_W-C_SUB_Y_SHIFT-1:0] start_y_chma,

   output cache_conf_pkg::luma_dim_t blk_wdt_luma,
   output cache_conf_pkg::luma_dim_t blk_hgt_luma,
   output cache_conf_pkg::luma_dim_t offset_x_luma,
   output cache_conf_pkg::luma_dim_t offset_y_luma,
   output cache_conf_pkg::luma_dim_t end_x_luma,
   output cache_conf_pkg::luma_dim_t end_y_luma,

   output cache_conf_pkg::chma_dim_t blk_wdt_chma,
   output cache_conf_pkg::chma_dim_t blk_hgt_chma,
   output cache_conf_pkg::chma_dim_t offset_x_chma,
   output cache_conf_pkg::chma_dim_t offset_y_chma,
   output cache_conf_pkg::chma_dim_t end_x_chma,
   output cache_conf_pkg::chma_dim_t end_y_chma
);

   // chroma start addresses lose the subsampling bits
   localparam type chma_xaddr_t = logic [cache_conf_pkg::X_ADDR_W-C_SUB_X_SHIFT-1:0];
   localparam type chma_yaddr_t = logic [cache_conf_pkg::Y_ADDR_W-C_SUB_Y_SHIFT-1:0];

   // ----------------------------------------------------------------------
   // per-axis clip results
   // ----------------------------------------------------------------------

   axis_clip_if #(
      .start_t(cache_conf_pkg::xaddr_t),
      .dim_t  (cache_conf_pkg::luma_dim_t)
   ) luma_x_clip ();

   axis_clip_if #(
      .start_t(cache_conf_pkg::yaddr_t),
      .dim_t  (cache_conf_pkg::luma_dim_t)
   ) luma_y_clip ();

   axis_clip_if #(
      .start_t(chma_xaddr_t),
      .dim_t  (cache_conf_pkg::chma_dim_t)
   ) chma_x_clip ();

   axis_clip_if #(
      .start_t(chma_yaddr_t),
      .dim_t  (cache_conf_pkg::chma_dim_t)
   ) chma_y_clip ();

   // ----------------------------------------------------------------------
   // clippers, x against width and y against height
   // ----------------------------------------------------------------------

   ref_axis_clip #(
      .SUB_SHIFT(0),
      .BLOCK_DIM(LUMA_BLOCK_DIM),
      .start_t  (cache_conf_pkg::xaddr_t),
      .dim_t    (cache_conf_pkg::luma_dim_t)
   ) u_luma_x_clip (
      .ref_start(luma_ref_start_x),
      .ref_size (luma_ref_width_x),
      .pic_dim  (pic_width),
      .clip     (luma_x_clip)
   );

   ref_axis_clip #(
      .SUB_SHIFT(0),
      .BLOCK_DIM(LUMA_BLOCK_DIM),
      .start_t  (cache_conf_pkg::yaddr_t),
      .dim_t    (cache_conf_pkg::luma_dim_t)
   ) u_luma_y_clip (
      .ref_start(luma_ref_start_y),
      .ref_size (luma_ref_height_y),
      .pic_dim  (pic_height),
      .clip     (luma_y_clip)
   );

   ref_axis_clip #(
      .SUB_SHIFT(C_SUB_X_SHIFT),
      .BLOCK_DIM(CHMA_BLOCK_WDT),
      .start_t  (chma_xaddr_t),
      .dim_t    (cache_conf_pkg::chma_dim_t)
   ) u_chma_x_clip (
      .ref_start(chma_ref_start_x),
      .ref_size (chma_ref_width_x),
      .pic_dim  (pic_width),
      .clip     (chma_x_clip)
   );

   ref_axis_clip #(
      .SUB_SHIFT(C_SUB_Y_SHIFT),
      .BLOCK_DIM(CHMA_BLOCK_HGT),
      .start_t  (chma_yaddr_t),
      .dim_t    (cache_conf_pkg::chma_dim_t)
   ) u_chma_y_clip (
      .ref_start(chma_ref_start_y),
      .ref_size (chma_ref_height_y),
      .pic_dim  (pic_height),
      .clip     (chma_y_clip)
   );

   // ----------------------------------------------------------------------
   // output register
   // ----------------------------------------------------------------------

   conf_register #(
      .C_SUB_X_SHIFT(C_SUB_X_SHIFT),
      .C_SUB_Y_SHIFT(C_SUB_Y_SHIFT)
   ) u_conf_register (
      .clk               (clk),
      .reset             (reset),
      .valid             (valid_in),
      .is_req_read       (is_req_read),
      .ready             (tag_compare_stage_ready),
      .ref_idx_in        (ref_idx_in),
      .luma_x            (luma_x_clip),
      .luma_y            (luma_y_clip),
      .chma_x            (chma_x_clip),
      .chma_y            (chma_y_clip),
      .op_conf_fifo_wr_en(op_conf_fifo_wr_en),
      .ref_idx           (ref_idx),
      .start_x_luma      (start_x_luma),
      .start_y_luma      (start_y_luma),
      .start_x_chma      (start_x_chma),
      .start_y_chma      (start_y_chma),
      .blk_wdt_luma      (blk_wdt_luma),
      .blk_hgt_luma      (blk_hgt_luma),
      .offset_x_luma     (offset_x_luma),
      .offset_y_luma     (offset_y_luma),
      .end_x_luma        (end_x_luma),
      .end_y_luma        (end_y_luma),
      .blk_wdt_chma      (blk_wdt_chma),
      .blk_hgt_chma      (blk_hgt_chma),
      .offset_x_chma     (offset_x_chma),
      .offset_y_chma     (offset_y_chma),
      .end_x_chma        (end_x_chma),
      .end_y_chma        (end_y_chma)
   );

endmodule

/* hw/conf_register.sv */
module conf_register #(
   parameter int C_SUB_X_SHIFT = 1,
   parameter int C_SUB_Y_SHIFT = 1
) (
   input  logic                     clk,
   input  logic                     reset,
   input  logic                     valid,
   input  logic                     is_req_read,
   input  logic                     ready,
   input  cache_conf_pkg::ref_idx_t ref_idx_in,

   axis_clip_if.dst                 luma_x,
   axis_clip_if.dst                 luma_y,
   axis_clip_if.dst                 chma_x,
   axis_clip_if.dst                 chma_y,

   output logic                     op_conf_fifo_wr_en,
   output cache_conf_pkg::ref_idx_t ref_idx,

   output cache_conf_pkg::xaddr_t   start_x_luma,
   output cache_conf_pkg::yaddr_t   start_y_luma,
   output logic [cache_conf_pkg::X_ADDR_W-C_SUB_X_SHIFT-1:0] start_x_chma,
   output logic [cache_conf_pkg::Y_ADDR_W-C_SUB_Y_SHIFT-1:0] start_y_chma,

   output cache_conf_pkg::luma_dim_t blk_wdt_luma,
   output cache_conf_pkg::luma_dim_t blk_hgt_luma,
   output cache_conf_pkg::luma_dim_t offset_x_luma,
   output cache_conf_pkg::luma_dim_t offset_y_luma,
   output cache_conf_pkg::luma_dim_t end_x_luma,
   output cache_conf_pkg::luma_dim_t end_y_luma,

   output cache_conf_pkg::chma_dim_t blk_wdt_chma,
   output cache_conf_pkg::chma_dim_t blk_hgt_chma,
   output cache_conf_pkg::chma_dim_t offset_x_chma,
   output cache_conf_pkg::chma_dim_t offset_y_chma,
   output cache_conf_pkg::chma_dim_t end_x_chma,
   output cache_conf_pkg::chma_dim_t end_y_chma
);

   logic accept;

   // ready doubles as the stall from the tag compare stage
   assign accept = valid && ready;

   // ----------------------------------------------------------------------
   // control
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         op_conf_fifo_wr_en <= 1'b0;
         ref_idx            <= '0;
      end else begin
         // one pulse per accepted read
         op_conf_fifo_wr_en <= accept && is_req_read;
         if (accept) begin
            ref_idx <= ref_idx_in;
         end
      end
   end

   // ----------------------------------------------------------------------
   // clip results
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (accept) begin
         // luma x
         start_x_luma  <= luma_x.clip_start;
         blk_wdt_luma  <= luma_x.span;
         offset_x_luma <= luma_x.offset;
         end_x_luma    <= luma_x.block_end;

         // luma y
         start_y_luma  <= luma_y.clip_start;
         blk_hgt_luma  <= luma_y.span;
         offset_y_luma <= luma_y.offset;
         end_y_luma    <= luma_y.block_end;

         // chroma x
         start_x_chma  <= chma_x.clip_start;
         blk_wdt_chma  <= chma_x.span;
         offset_x_chma <= chma_x.offset;
         end_x_chma    <= chma_x.block_end;

         // chroma y
         start_y_chma  <= chma_y.clip_start;
         blk_hgt_chma  <= chma_y.span;
         offset_y_chma <= chma_y.offset;
         end_y_chma    <= chma_y.block_end;
      end
   end

endmodule

/* hw/ref_axis_clip.sv */
module ref_axis_clip #(
   parameter int  SUB_SHIFT = 0,
   parameter int  BLOCK_DIM = cache_conf_pkg::DEF_LUMA_BLOCK_DIM,
   parameter type start_t   = cache_conf_pkg::xaddr_t,
   parameter type dim_t     = cache_conf_pkg::luma_dim_t
) (
   input  cache_conf_pkg::coord_t    ref_start,
   input  cache_conf_pkg::luma_dim_t ref_size,
   input  cache_conf_pkg::coord_t    pic_dim,
   axis_clip_if.src                  clip
);

   localparam int START_W = $bits(start_t);
   localparam int DIM_W   = $bits(dim_t);
   localparam int SIGN    = cache_conf_pkg::COORD_W - 1;

   localparam dim_t                   BLOCK_LAST = dim_t'(BLOCK_DIM - 1);
   localparam cache_conf_pkg::coord_t COORD_ONE  = 1;

   cache_conf_pkg::coord_t size_ext;
   cache_conf_pkg::coord_t end_coord;
   cache_conf_pkg::coord_t edge_rem;
   cache_conf_pkg::coord_t neg_start;
   cache_conf_pkg::coord_t last_start;

   cache_conf_pkg::coord_t start_sh;
   cache_conf_pkg::coord_t end_sh;
   cache_conf_pkg::coord_t rem_sh;
   cache_conf_pkg::coord_t neg_sh;
   cache_conf_pkg::coord_t size_sh;

   logic start_neg;
   logic end_neg;
   logic rem_neg;
   logic start_past;
   logic end_past;

   // ----------------------------------------------------------------------
   // edge distances
   // ----------------------------------------------------------------------

   assign size_ext   = {{(cache_conf_pkg::COORD_W-cache_conf_pkg::LUMA_DIM_W){1'b0}}, ref_size};
   assign end_coord  = ref_start + size_ext;
   // pixels left between the start and the last column or row
   assign edge_rem   = pic_dim - COORD_ONE - ref_start;
   assign neg_start  = -ref_start;
   assign last_start = (pic_dim >> SUB_SHIFT) - COORD_ONE;

   assign start_neg  = ref_start[SIGN];
   assign end_neg    = end_coord[SIGN];
   assign rem_neg    = edge_rem[SIGN];
   assign start_past = (ref_start >= pic_dim);
   assign end_past   = (end_coord >= pic_dim);

   // all shifted values are non-negative where they get used
   assign start_sh = ref_start >> SUB_SHIFT;
   assign end_sh   = end_coord >> SUB_SHIFT;
   assign rem_sh   = edge_rem >> SUB_SHIFT;
   assign neg_sh   = neg_start >> SUB_SHIFT;
   assign size_sh  = size_ext >> SUB_SHIFT;

   // ----------------------------------------------------------------------
   // clamped start
   // ----------------------------------------------------------------------

   always_comb begin
      if (start_neg) begin
         clip.clip_start = '0;
      end else if (start_past) begin
         clip.clip_start = last_start[START_W-1:0];
      end else begin
         clip.clip_start = start_sh[START_W-1:0];
      end
   end

   // ----------------------------------------------------------------------
   // span, offset and end inside the block
   // ----------------------------------------------------------------------

   always_comb begin
      clip.offset = '0;
      if (start_neg) begin
         // starts above or left of the picture
         clip.block_end = BLOCK_LAST;
         if (end_neg) begin
            clip.offset = BLOCK_LAST;
            clip.span   = '0;
         end else begin
            clip.offset = neg_sh[DIM_W-1:0];
            clip.span   = end_sh[DIM_W-1:0];
         end
      end else if (end_past) begin
         // runs over the right or bottom edge
         if (rem_neg) begin
            clip.span      = '0;
            clip.block_end = '0;
         end else begin
            clip.span      = rem_sh[DIM_W-1:0];
            clip.block_end = rem_sh[DIM_W-1:0];
         end
      end else begin
         clip.span      = size_sh[DIM_W-1:0];
         clip.block_end = size_sh[DIM_W-1:0];
      end
   end

endmodule

/* verification/conf_model.svh */
`ifndef CONF_MODEL_SVH
`define CONF_MODEL_SVH

// expected clip result of one axis, full integer range
typedef struct {
   int start;
   int span;
   int offset;
   int block_end;
} axis_exp_t;

// s start, w extent, p picture dimension, k subsampling shift, b block dimension
function automatic axis_exp_t clip_axis(input int s, input int w, input int p,
                                        input int k, input int b);
   axis_exp_t r;
   int e;
   int rem;
   e   = s + w;
   rem = p - 1 - s;

   if (s < 0) begin
      r.start = 0;
   end else if (s >= p) begin
      r.start = (p >>> k) - 1;
   end else begin
      r.start = s >>> k;
   end

   r.offset = 0;
   if (s < 0) begin
      r.block_end = b - 1;
      if (e < 0) begin
         r.offset = b - 1;
         r.span   = 0;
      end else begin
         r.span   = e >>> k;
         r.offset = (-s) >>> k;
      end
   end else if (e >= p) begin
      // nothing left inside the picture
      if (rem < 0) begin
         r.span      = 0;
         r.block_end = 0;
      end else begin
         r.span      = rem >>> k;
         r.block_end = rem >>> k;
      end
   end else begin
      r.span      = w >>> k;
      r.block_end = w >>> k;
   end
   return r;
endfunction

`endif

/* verification/tb_cache_conf_stage.sv */
module tb_cache_conf_stage;
   timeunit 1ns;
   timeprecision 1ps;

   `include "conf_model.svh"

   localparam int LUMA_BLOCK_DIM = 64;
   localparam int CHMA_BLOCK_WDT = 32;
   localparam int CHMA_BLOCK_HGT = 32;
   localparam int C_SUB_X_SHIFT  = 1;
   localparam int C_SUB_Y_SHIFT  = 1;

   localparam int N_DIRECTED = 7;
   localparam int N_RANDOM   = 400;
   localparam int MAX_STALL  = 8;
   // every request takes at most one cycle, the stall and three idle cycles
   localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM) * (MAX_STALL + 4) * 20 + 1000;

   localparam int XW  = cache_conf_pkg::X_ADDR_W;
   localparam int YW  = cache_conf_pkg::Y_ADDR_W;
   localparam int LDW = cache_conf_pkg::LUMA_DIM_W;
   localparam int CDW = cache_conf_pkg::CHMA_DIM_W;

   typedef struct {
      axis_exp_t lx;
      axis_exp_t ly;
      axis_exp_t cx;
      axis_exp_t cy;
      int        idx;
   } req_exp_t;

   logic clk;
   logic reset;
   logic valid_in;
   logic is_req_read;
   logic tag_compare_stage_ready;
   cache_conf_pkg::coord_t    pic_width;
   cache_conf_pkg::coord_t    pic_height;
   cache_conf_pkg::ref_idx_t  ref_idx_in;
   cache_conf_pkg::coord_t    luma_ref_start_x;
   cache_conf_pkg::coord_t    luma_ref_start_y;
   cache_conf_pkg::coord_t    chma_ref_start_x;
   cache_conf_pkg::coord_t    chma_ref_start_y;
   cache_conf_pkg::luma_dim_t luma_ref_width_x;
   cache_conf_pkg::luma_dim_t luma_ref_height_y;
   cache_conf_pkg::luma_dim_t chma_ref_width_x;
   cache_conf_pkg::luma_dim_t chma_ref_height_y;

   logic                                   op_conf_fifo_wr_en;
   cache_conf_pkg::ref_idx_t               ref_idx;
   cache_conf_pkg::xaddr_t                 start_x_luma;
   cache_conf_pkg::yaddr_t                 start_y_luma;
   logic [XW-C_SUB_X_SHIFT-1:0]            start_x_chma;
   logic [YW-C_SUB_Y_SHIFT-1:0]            start_y_chma;
   cache_conf_pkg::luma_dim_t blk_wdt_luma;
   cache_conf_pkg::luma_dim_t blk_hgt_luma;
   cache_conf_pkg::luma_dim_t offset_x_luma;
   cache_conf_pkg::luma_dim_t offset_y_luma;
   cache_conf_pkg::luma_dim_t end_x_luma;
   cache_conf_pkg::luma_dim_t end_y_luma;
   cache_conf_pkg::chma_dim_t blk_wdt_chma;
   cache_conf_pkg::chma_dim_t blk_hgt_chma;
   cache_conf_pkg::chma_dim_t offset_x_chma;
   cache_conf_pkg::chma_dim_t offset_y_chma;
   cache_conf_pkg::chma_dim_t end_x_chma;
   cache_conf_pkg::chma_dim_t end_y_chma;

   req_exp_t exp_q[$];
   req_exp_t cur;
   bit       have_ref;
   bit       pulse_due;
   bit       rand_ready;

   cache_conf_stage #(
      .LUMA_BLOCK_DIM(LUMA_BLOCK_DIM),
      .CHMA_BLOCK_WDT(CHMA_BLOCK_WDT),
      .CHMA_BLOCK_HGT(CHMA_BLOCK_HGT),
      .C_SUB_X_SHIFT (C_SUB_X_SHIFT),
      .C_SUB_Y_SHIFT (C_SUB_Y_SHIFT)
   ) dut (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // checking
   // ----------------------------------------------------------------------

   task automatic check_val(input string name, input logic [31:0] act, input int exp,
                            input int width);
      logic [31:0] want;
      want = 32'(exp) & ((32'd1 << width) - 32'd1);
      assert (act === want) else begin
         $display("FAILED at %0d ns: %s expected %0d, got %0d", $time, name, want, act);
         $display("Some tests failed");
         $fatal(1, "output mismatch");
      end
   endtask

   task automatic check_axis(input axis_exp_t e, input string axis, input string span_name,
                             input logic [31:0] st, input logic [31:0] sp,
                             input logic [31:0] of, input logic [31:0] en,
                             input int sw, input int dw);
      check_val({"start_", axis}, st, e.start, sw);
      check_val(span_name, sp, e.span, dw);
      check_val({"offset_", axis}, of, e.offset, dw);
      check_val({"end_", axis}, en, e.block_end, dw);
   endtask

   function automatic req_exp_t expect_req();
      req_exp_t r;
      r.lx  = clip_axis(luma_ref_start_x, luma_ref_width_x, pic_width, 0, LUMA_BLOCK_DIM);
      r.ly  = clip_axis(luma_ref_start_y, luma_ref_height_y, pic_height, 0, LUMA_BLOCK_DIM);
      r.cx  = clip_axis(chma_ref_start_x, chma_ref_width_x, pic_width, C_SUB_X_SHIFT,
                        CHMA_BLOCK_WDT);
      r.cy  = clip_axis(chma_ref_start_y, chma_ref_height_y, pic_height, C_SUB_Y_SHIFT,
                        CHMA_BLOCK_HGT);
      r.idx = ref_idx_in;
      return r;
   endfunction

   // outputs must match the last accepted request on every cycle
   always @(posedge clk) begin
      if (reset) begin
         exp_q.delete();
         have_ref  = 1'b0;
         pulse_due = 1'b0;
      end else begin
         check_val("op_conf_fifo_wr_en", op_conf_fifo_wr_en, pulse_due, 1);
         if (exp_q.size() > 0) begin
            cur      = exp_q.pop_front();
            have_ref = 1'b1;
         end
         if (have_ref) begin
            check_val("ref_idx", ref_idx, cur.idx, cache_conf_pkg::REF_IDX_W);
            check_axis(cur.lx, "x_luma", "blk_wdt_luma", start_x_luma, blk_wdt_luma,
                       offset_x_luma, end_x_luma, XW, LDW);
            check_axis(cur.ly, "y_luma", "blk_hgt_luma", start_y_luma, blk_hgt_luma,
                       offset_y_luma, end_y_luma, YW, LDW);
            check_axis(cur.cx, "x_chma", "blk_wdt_chma", start_x_chma, blk_wdt_chma,
                       offset_x_chma, end_x_chma, XW - C_SUB_X_SHIFT, CDW);
            check_axis(cur.cy, "y_chma", "blk_hgt_chma", start_y_chma, blk_hgt_chma,
                       offset_y_chma, end_y_chma, YW - C_SUB_Y_SHIFT, CDW);
         end else begin
            check_val("ref_idx", ref_idx, 0, cache_conf_pkg::REF_IDX_W);
         end
         pulse_due = valid_in && tag_compare_stage_ready && is_req_read;
         if (valid_in && tag_compare_stage_ready) begin
            exp_q.push_back(expect_req());
         end
      end
   end

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------

   task automatic send_req(input int sx, input int sy, input int csx, input int csy,
                           input int w, input int h, input int cw, input int ch,
                           input bit rd);
      int stall;
      stall = 0;
      @(negedge clk);
      luma_ref_start_x        = 16'(sx);
      luma_ref_start_y        = 16'(sy);
      chma_ref_start_x        = 16'(csx);
      chma_ref_start_y        = 16'(csy);
      luma_ref_width_x        = 7'(w);
      luma_ref_height_y       = 7'(h);
      chma_ref_width_x        = 7'(cw);
      chma_ref_height_y       = 7'(ch);
      is_req_read             = rd;
      ref_idx_in              = 4'($urandom);
      valid_in                = 1'b1;
      tag_compare_stage_ready = rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
      @(posedge clk);
      // upstream holds the request through the stall
      while (!tag_compare_stage_ready) begin
         @(negedge clk);
         stall++;
         tag_compare_stage_ready = (stall >= MAX_STALL) || ($urandom_range(0, 3) != 0);
         @(posedge clk);
      end
      @(negedge clk);
      valid_in                = 1'b0;
      tag_compare_stage_ready = rand_ready ? 1'($urandom) : 1'b0;
      // random idle gap before the next request
      if (rand_ready) begin
         repeat ($urandom_range(0, 2)) @(negedge clk);
      end
   endtask

   function automatic int rand_start(input int p);
      return int'($urandom_range(0, p + 200)) - 150;
   endfunction

   initial begin
      int pic_w;
      int pic_h;
      void'($urandom(32'hec4f_6f2a));
      rand_ready              = 1'b0;
      reset                   = 1'b1;
      valid_in                = 1'b0;
      is_req_read             = 1'b0;
      tag_compare_stage_ready = 1'b0;
      pic_width               = 16'd1920;
      pic_height              = 16'd1080;
      ref_idx_in              = '0;
      luma_ref_start_x        = '0;
      luma_ref_start_y        = '0;
      chma_ref_start_x        = '0;
      chma_ref_start_y        = '0;
      luma_ref_width_x        = '0;
      luma_ref_height_y       = '0;
      chma_ref_width_x        = '0;
      chma_ref_height_y       = '0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      repeat (2) @(negedge clk);

      // interior, left/top, right/bottom and last pixel cases
      send_req(128, 64, 130, 66, 64, 32, 64, 32, 1'b1);
      send_req(500, 300, 501, 301, 17, 9, 17, 9, 1'b0);
      send_req(-10, -21, -11, -20, 40, 40, 40, 40, 1'b1);
      send_req(-100, -80, -90, -70, 16, 16, 16, 16, 1'b1);
      send_req(1900, 1060, 1901, 1061, 64, 64, 64, 64, 1'b1);
      send_req(1950, 1100, 1930, 1090, 16, 16, 16, 16, 1'b0);
      send_req(1919, 1079, 1919, 1079, 8, 8, 8, 8, 1'b1);

      rand_ready = 1'b1;
      pic_w      = 1920;
      pic_h      = 1080;
      for (int i = 0; i < N_RANDOM; i++) begin
         if (i % 50 == 0) begin
            pic_w      = 64 + int'($urandom_range(0, 4000));
            pic_h      = 64 + int'($urandom_range(0, 4000));
            pic_width  = 16'(pic_w);
            pic_height = 16'(pic_h);
         end
         send_req(rand_start(pic_w), rand_start(pic_h), rand_start(pic_w), rand_start(pic_h),
                  $urandom_range(0, 127), $urandom_range(0, 127),
                  $urandom_range(0, 127), $urandom_range(0, 127), 1'($urandom));
      end

      repeat (2) @(posedge clk);
      @(negedge clk);
      $display("All tests passed");
      $finish;
   end

   initial begin
      #(TIMEOUT_NS);
      $display("the run did not finish before the watchdog expired");
      $display("Some tests failed");
      $fatal(1, "timeout");
   end

endmodule
